// ==== all.f ====
+incdir+include
verilog/opn_bus_pkg.sv
verilog/opn_timer_pkg.sv
verilog/opn_regs.sv
verilog/opn_prescaler.sv
verilog/opn_timer.sv
verilog/opn_lfo.sv
verilog/opn_top.sv
test/opn_tb.sv

// ==== include/opn_params.svh ====
`ifndef OPN_PARAMS_SVH
`define OPN_PARAMS_SVH

// Datapath widths
`define OPN_DATA_W      8       // CPU data bus
`define OPN_TA_W        10      // Timer A counter
`define OPN_TB_W        8       // Timer B counter
`define OPN_LFO_W       7       // LFO modulation counter

// Prescaler rates
`define OPN_CEN_DIV     6       // Clocks per FM clock enable
`define OPN_TA_CENS     24      // FM enables per timer A tick
`define OPN_TB_RATIO    16      // Timer A ticks per timer B tick

// Write recovery time
`define OPN_BUSY_CLKS   32      // Clocks of busy after a data write

// Register map, low bank only
`define OPN_REG_LFO     8'h22   // LFO enable and rate
`define OPN_REG_TA_HI   8'h24   // Timer A bits 9..2
`define OPN_REG_TA_LO   8'h25   // Timer A bits 1..0
`define OPN_REG_TB      8'h26   // Timer B value
`define OPN_REG_TCTL    8'h27   // Timer load, enable and reset

`endif

// ==== run.sh ====
#!/bin/sh
# Build and run the OPN control testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module opn_tb \
    -f all.f --Mdir obj_dir -o opn_tb_sim
./obj_dir/opn_tb_sim > sim.log 2>&1 || true
cat sim.log
if grep -qF '*** TEST FAILED ***' sim.log; then
    echo "simulation reported failure"
    exit 1
fi
if ! grep -qF '*** TEST PASSED ***' sim.log; then
    echo "simulation ended without a result"
    exit 1
fi

// ==== test/opn_tb.sv ====
`timescale 1ns/1ps
`include "opn_params.svh"

module opn_tb;

    localparam int TA_CLKS = `OPN_CEN_DIV * `OPN_TA_CENS;   // Clocks per timer A tick
    localparam int TB_CLKS = TA_CLKS * `OPN_TB_RATIO;       // Clocks per timer B tick
    // FM enables per LFO step for freq 0 to 7
    localparam int LFO_PERIOD [8] = '{108, 77, 71, 67, 62, 44, 8, 5};

    // One table row is a bus write or a timed check
    typedef struct packed {
        logic                   is_write;
        logic [7:0]             addr;
        logic [7:0]             data;
        logic [31:0]            wait_clks;  // Clocks after the previous row
        opn_bus_pkg::status_t   exp_status;
        logic                   exp_irq_n;
        logic [`OPN_LFO_W-1:0]  exp_lfo;
    } step_t;

    logic                   zero = 1'b0;
    logic                   rst_n;
    logic                   cs_n;
    logic                   wr_n;
    logic                   a0;
    logic [`OPN_DATA_W-1:0] din;
    logic [`OPN_DATA_W-1:0] dout;
    logic                   irq_n;
    logic [`OPN_LFO_W-1:0]  lfo_mod;

    step_t steps[$];
    int    since = 0;               // Clocks since the last data write
    logic  wrote = 1'b0;            // No data write yet
    int    total_clks = 0;          // Table length in clocks
    int    limit = 32'h7fff_ffff;   // Set once the table is known
    int    cycles = 0;

    opn_top dut (
        .zero    (zero),
        .rst_n   (rst_n),
        .cs_n    (cs_n),
        .wr_n    (wr_n),
        .a0      (a0),
        .din     (din),
        .dout    (dout),
        .irq_n   (irq_n),
        .lfo_mod (lfo_mod)
    );

    always #2 zero = ~zero;     // 4 ns period

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("*** TEST FAILED ***");
        $fatal(1, "run stopped at the first error");
    endtask

    // Cycle limit
    always @(posedge zero) begin
        cycles <= cycles + 1;
        if (cycles > limit) begin
            abort_run($sformatf("timeout: no result after %0d clocks", cycles));
        end
    end

    task automatic check_status(input opn_bus_pkg::status_t got, input opn_bus_pkg::status_t exp);
        if (got !== exp) begin
            abort_run($sformatf("mismatch status: got %h expected %h", got, exp));
        end
    endtask

    // Reserved status bits read as zero
    task automatic check_pad(input logic [`OPN_DATA_W-4:0] got);
        if (got !== '0) begin
            abort_run($sformatf("mismatch dout[6:2]: got %h expected %h", got, 5'h00));
        end
    endtask

    task automatic check_irq(input logic got, input logic exp);
        if (got !== exp) begin
            abort_run($sformatf("mismatch irq_n: got %h expected %h", got, exp));
        end
    endtask

    task automatic check_lfo(input logic [`OPN_LFO_W-1:0] got, input logic [`OPN_LFO_W-1:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("mismatch lfo_mod: got %h expected %h", got, exp));
        end
    endtask

    // Table builders
    task automatic add_write(input logic [7:0] addr, input logic [7:0] data);
        step_t s;
        s = '0;
        s.is_write = 1'b1;
        s.addr     = addr;
        s.data     = data;
        steps.push_back(s);
        since = 0;
        wrote = 1'b1;
        total_clks += `OPN_BUSY_CLKS + 4;   // Busy wait, address and data clocks
    endtask

    // at counts clocks after the last data write
    task automatic add_check(input int at, input logic fa, input logic fb, input logic irq,
                             input logic [`OPN_LFO_W-1:0] lfo);
        step_t s;
        s = '0;
        s.wait_clks         = 32'(at - since);
        s.exp_status.busy   = wrote && at >= 1 && at <= `OPN_BUSY_CLKS;
        s.exp_status.flag_b = fb;
        s.exp_status.flag_a = fa;
        s.exp_irq_n         = irq;
        s.exp_lfo           = lfo;
        steps.push_back(s);
        total_clks += at - since;
        since = at;
    endtask

    // Latest clock at which a flag cannot have risen yet for any tick phase
    function automatic int quiet_until(input int n_ticks, input int tick_clks);
        return (n_ticks > 1) ? (n_ticks - 1) * tick_clks : 1;
    endfunction

    task automatic bus_write(input logic [7:0] addr, input logic [7:0] data);
        @(posedge zero);
        #1;
        while (dout[7]) begin   // Wait out busy
            @(posedge zero);
            #1;
        end
        cs_n = 1'b0;
        wr_n = 1'b0;
        a0   = 1'b0;
        din  = addr;            // Address cycle
        @(posedge zero);
        #1;
        a0  = 1'b1;
        din = data;             // Data cycle
        @(posedge zero);        // Register loads on this edge
        #1;
        cs_n = 1'b1;
        wr_n = 1'b1;
        a0   = 1'b0;
        din  = '0;
    endtask

    initial begin
        int unsigned          seed;
        logic [`OPN_TA_W-1:0] val_a;
        logic [`OPN_TB_W-1:0] val_b;
        logic [2:0]           freq;
        int                   n_a;
        int                   n_b;
        int                   per;
        opn_bus_pkg::status_t got_st;
        rst_n = 1'b0;
        cs_n  = 1'b1;
        wr_n  = 1'b1;
        a0    = 1'b0;
        din   = '0;
        seed  = 32'h081e_7d0b;
        void'($urandom(seed));
        val_a = 10'h3F0 + 10'($urandom % 16);
        val_b = 8'hFD + 8'($urandom % 3);
        freq  = 3'($urandom % 8);
        n_a   = 1024 - int'(val_a);     // Ticks to overflow
        n_b   = 256 - int'(val_b);
        per   = LFO_PERIOD[freq] * `OPN_CEN_DIV;   // Clocks per LFO step

        add_check(1, 1'b0, 1'b0, 1'b1, 7'd0);               // Reset state
        add_write(`OPN_REG_TA_HI, val_a[9:2]);
        add_check(1, 1'b0, 1'b0, 1'b1, 7'd0);               // Busy window
        add_check(`OPN_BUSY_CLKS, 1'b0, 1'b0, 1'b1, 7'd0);
        add_check(`OPN_BUSY_CLKS + 1, 1'b0, 1'b0, 1'b1, 7'd0);
        add_write(`OPN_REG_TA_LO, {6'd0, val_a[1:0]});
        add_write(`OPN_REG_TCTL, 8'h05);                    // load_a, irq_en_a
        add_check(quiet_until(n_a, TA_CLKS), 1'b0, 1'b0, 1'b1, 7'd0);
        add_check(n_a * TA_CLKS + 2, 1'b1, 1'b0, 1'b0, 7'd0);
        add_write(`OPN_REG_TB, val_b);
        add_write(`OPN_REG_TCTL, 8'h0A);                    // B runs while A stops and keeps its flag
        add_check(quiet_until(n_b, TB_CLKS), 1'b1, 1'b0, 1'b0, 7'd0);
        add_check(n_b * TB_CLKS + 2, 1'b1, 1'b1, 1'b0, 7'd0);
        add_write(`OPN_REG_TCTL, 8'h10);                    // clr_a
        add_check(2, 1'b0, 1'b1, 1'b0, 7'd0);
        add_check(`OPN_BUSY_CLKS + 8, 1'b0, 1'b1, 1'b0, 7'd0);
        add_write(`OPN_REG_TCTL, 8'h20);                    // clr_b
        add_check(2, 1'b0, 1'b0, 1'b1, 7'd0);
        add_write(`OPN_REG_LFO, {4'h0, 1'b1, freq});
        add_check(2, 1'b0, 1'b0, 1'b1, 7'd0);
        add_check(3 * per + 3, 1'b0, 1'b0, 1'b1, 7'd3);
        add_check(130 * per + 3, 1'b0, 1'b0, 1'b1, 7'(130 % 128));  // Past the wrap
        add_write(`OPN_REG_LFO, 8'h00);
        add_check(1, 1'b0, 1'b0, 1'b1, 7'd0);
        add_write(`OPN_REG_TCTL, 8'h01);                    // load_a with the flag masked
        add_check(n_a * TA_CLKS + 2, 1'b0, 1'b0, 1'b1, 7'd0);
        add_check(2 * n_a * TA_CLKS + TA_CLKS + 2, 1'b0, 1'b0, 1'b1, 7'd0);
        limit = total_clks + 5 + (total_clks + 5) / 10;

        repeat (5) @(posedge zero);
        #1;
        rst_n = 1'b1;

        foreach (steps[i]) begin
            if (steps[i].is_write) begin
                bus_write(steps[i].addr, steps[i].data);
            end else begin
                repeat (steps[i].wait_clks) @(posedge zero);
                #1;
                got_st = {dout[7], dout[1], dout[0]};   // busy, flag_b, flag_a
                check_status(got_st, steps[i].exp_status);
                check_pad(dout[6:2]);
                check_irq(irq_n, steps[i].exp_irq_n);
                check_lfo(lfo_mod, steps[i].exp_lfo);
            end
        end

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

// ==== verilog/opn_bus_pkg.sv ====
package opn_bus_pkg;

    // Status word as seen on dout
    // dout[7] busy, dout[1] flag B, dout[0] flag A
    typedef struct packed {
        logic busy;     // Write recovery in progress
        logic flag_b;   // Timer B overflowed
        logic flag_a;   // Timer A overflowed
    } status_t;

    // Byte written to register 0x27
    // Bit 0 is load_a, bit 5 is clr_b
    typedef struct packed {
        logic [1:0] unused;     // Mode bits, not kept here
        logic       clr_b;      // Write 1 to drop flag B
        logic       clr_a;      // Write 1 to drop flag A
        logic       irq_en_b;   // Flag B may set
        logic       irq_en_a;   // Flag A may set
        logic       load_b;     // Timer B runs
        logic       load_a;     // Timer A runs
    } timer_ctl_t;

endpackage

// ==== verilog/opn_lfo.sv ====
`timescale 1ns/1ps
`include "opn_params.svh"

module opn_lfo (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    cen_fm,
    input  opn_timer_pkg::lfo_cfg_t cfg,
    output logic [`OPN_LFO_W-1:0]   lfo_mod
);

    logic [6:0] div_cnt;    // Counts FM enables, up to 108
    logic [6:0] period;
    logic       step;

    // FM enables per LFO step, slowest rate first
    always_comb begin
        case (cfg.freq)
            3'd0:    period = 7'd108;
            3'd1:    period = 7'd77;
            3'd2:    period = 7'd71;
            3'd3:    period = 7'd67;
            3'd4:    period = 7'd62;
            3'd5:    period = 7'd44;
            3'd6:    period = 7'd8;
            default: period = 7'd5;
        endcase
    end

    // >= so a rate change mid period cannot overrun
    assign step = cen_fm && (div_cnt >= period - 1'b1);

    always_ff @(posedge clk) begin
        if (!rst_n || !cfg.en) begin
            div_cnt <= '0;      // Disabled, hold both at zero
            lfo_mod <= '0;
        end else if (cen_fm) begin
            if (step) begin
                div_cnt <= '0;
                lfo_mod <= lfo_mod + 1'b1;  // Wraps at 128
            end else begin
                div_cnt <= div_cnt + 1'b1;
            end
        end
    end

    // Output cleared the clock after disable
    a_lfo_off: assert property (@(posedge clk) disable iff (!rst_n)
        !cfg.en |=> lfo_mod == '0)
        else $error("lfo_mod nonzero while disabled");

endmodule

// ==== verilog/opn_prescaler.sv ====
`timescale 1ns/1ps
`include "opn_params.svh"

module opn_prescaler (
    input  logic                  clk,
    input  logic                  rst_n,
    output opn_timer_pkg::ticks_t ticks
);

    localparam int CEN_W = $clog2(`OPN_CEN_DIV);
    localparam int TA_W  = $clog2(`OPN_TA_CENS);
    localparam int TB_W  = $clog2(`OPN_TB_RATIO);

    logic [CEN_W-1:0] cen_cnt;
    logic [TA_W-1:0]  ta_cnt;
    logic [TB_W-1:0]  tb_cnt;
    logic             cen_now, ta_now, tb_now;

    // Each stage only moves on the strobe of the one before
    assign cen_now = (cen_cnt == CEN_W'(`OPN_CEN_DIV - 1));
    assign ta_now  = cen_now && (ta_cnt == TA_W'(`OPN_TA_CENS - 1));
    assign tb_now  = ta_now && (tb_cnt == TB_W'(`OPN_TB_RATIO - 1));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cen_cnt <= '0;
            ta_cnt  <= '0;
            tb_cnt  <= '0;
            ticks   <= '0;
        end else begin
            cen_cnt <= cen_now ? '0 : cen_cnt + 1'b1;
            if (cen_now) ta_cnt <= ta_now ? '0 : ta_cnt + 1'b1;
            if (ta_now)  tb_cnt <= tb_now ? '0 : tb_cnt + 1'b1;
            ticks <= '{cen_fm: cen_now, tick_a: ta_now, tick_b: tb_now};  // Registered strobes
        end
    end

    // Timer B tick is a subset of timer A ticks
    a_tick_b_sub: assert property (@(posedge clk) disable iff (!rst_n)
        ticks.tick_b |-> ticks.tick_a && ticks.cen_fm)
        else $error("tick_b without tick_a");

endmodule

// ==== verilog/opn_regs.sv ====
`timescale 1ns/1ps
`include "opn_params.svh"

module opn_regs (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      cs_n,
    input  logic                      wr_n,
    input  logic                      a0,
    input  logic [`OPN_DATA_W-1:0]    din,
    input  logic                      flag_a,
    input  logic                      flag_b,
    output opn_timer_pkg::timer_cfg_t timer_cfg,
    output logic                      clr_a,
    output logic                      clr_b,
    output opn_timer_pkg::lfo_cfg_t   lfo_cfg,
    output logic [`OPN_DATA_W-1:0]    dout,
    output logic                      irq_n
);

    localparam int BUSY_W = $clog2(`OPN_BUSY_CLKS + 1);

    logic                     wr_cyc;     // cs_n and wr_n both low
    logic                     data_wr;    // Write with a0 high
    logic                     tctl_wr;    // Data write hitting 0x27
    logic [`OPN_DATA_W-1:0]   addr_q;     // Latched register address
    logic [BUSY_W-1:0]        busy_cnt;
    opn_bus_pkg::timer_ctl_t  ctl;
    opn_bus_pkg::status_t     status;

    assign wr_cyc  = !cs_n && !wr_n;
    assign data_wr = wr_cyc && a0;
    assign tctl_wr = data_wr && (addr_q == `OPN_REG_TCTL);
    assign ctl     = opn_bus_pkg::timer_ctl_t'(din);   // 0x27 view of the bus

    // Address phase
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            addr_q <= '0;
        end else if (wr_cyc && !a0) begin
            addr_q <= din;
        end
    end

    // Data phase, register updates on the sampling edge
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            timer_cfg <= '0;
            lfo_cfg   <= '0;
        end else if (data_wr) begin
            case (addr_q)
                `OPN_REG_LFO:   lfo_cfg <= opn_timer_pkg::lfo_cfg_t'(din[3:0]);
                `OPN_REG_TA_HI: timer_cfg.value_a[`OPN_TA_W-1:2] <= din;
                `OPN_REG_TA_LO: timer_cfg.value_a[1:0] <= din[1:0];
                `OPN_REG_TB:    timer_cfg.value_b <= din;
                `OPN_REG_TCTL: begin
                    timer_cfg.load_a   <= ctl.load_a;
                    timer_cfg.load_b   <= ctl.load_b;
                    timer_cfg.irq_en_a <= ctl.irq_en_a;
                    timer_cfg.irq_en_b <= ctl.irq_en_b;
                end
                default: ;  // Unmapped address, write ignored
            endcase
        end
    end

    // Flag reset strobes, one clock wide
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            clr_a <= 1'b0;
            clr_b <= 1'b0;
        end else begin
            clr_a <= tctl_wr && ctl.clr_a;
            clr_b <= tctl_wr && ctl.clr_b;
        end
    end

    // Busy period
    // A write during busy is taken but does not restart the count
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy_cnt <= '0;
        end else if (data_wr && busy_cnt == '0) begin
            busy_cnt <= BUSY_W'(`OPN_BUSY_CLKS);
        end else if (busy_cnt != '0) begin
            busy_cnt <= busy_cnt - 1'b1;
        end
    end

    always_comb begin
        status.busy   = (busy_cnt != '0);
        status.flag_b = flag_b;
        status.flag_a = flag_a;
    end

    // Status byte and interrupt, both registered
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            dout  <= '0;
            irq_n <= 1'b1;
        end else begin
            dout  <= {status.busy, {(`OPN_DATA_W-3){1'b0}}, status.flag_b, status.flag_a};
            irq_n <= !(flag_a || flag_b);   // Low while any flag stands
        end
    end

    // Busy drops within the recovery time
    a_busy_len: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(status.busy) |-> ##[1:`OPN_BUSY_CLKS] !status.busy)
        else $error("busy held past %0d clocks", `OPN_BUSY_CLKS);

endmodule

// ==== verilog/opn_timer.sv ====
`timescale 1ns/1ps

module opn_timer #(
    parameter int WIDTH = 10
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             tick,
    input  logic [WIDTH-1:0] value,
    input  logic             load,
    input  logic             irq_en,
    input  logic             clr,
    output logic             flag
);

    logic [WIDTH-1:0] cnt;
    logic             ovf;    // Wrap on this tick

    // Count tops out at all ones, period is 2^WIDTH - value
    assign ovf = load && tick && (cnt == '1);

    // Counter
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cnt <= '0;
        end else if (!load) begin
            cnt <= value;       // Stopped, follow the register
        end else if (tick) begin
            if (ovf) begin
                cnt <= value;   // Reload on wrap
            end else begin
                cnt <= cnt + 1'b1;
            end
        end
    end

    // Overflow flag
    // A wrap wins over a clear landing on the same clock
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            flag <= 1'b0;
        end else if (ovf && irq_en) begin
            flag <= 1'b1;
        end else if (clr) begin
            flag <= 1'b0;
        end
    end

    // Masked timer never reports
    a_flag_masked: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(flag) |-> $past(irq_en))
        else $error("flag rose with irq_en low");

endmodule

// ==== verilog/opn_timer_pkg.sv ====
`include "opn_params.svh"

package opn_timer_pkg;

    // Single clock strobes out of the prescaler
    typedef struct packed {
        logic cen_fm;   // FM clock enable, every 6 clocks
        logic tick_a;   // Timer A step
        logic tick_b;   // Timer B step, only together with tick_a
    } ticks_t;

    // Timer settings held by the register block
    typedef struct packed {
        logic [`OPN_TA_W-1:0] value_a;  // Reload value A
        logic [`OPN_TB_W-1:0] value_b;  // Reload value B
        logic                 load_a;   // Count A while high
        logic                 load_b;   // Count B while high
        logic                 irq_en_a; // Let A raise its flag
        logic                 irq_en_b; // Let B raise its flag
    } timer_cfg_t;

    // LFO register, low nibble of 0x22
    typedef struct packed {
        logic       en;     // Bit 3
        logic [2:0] freq;   // Rate select 0..7
    } lfo_cfg_t;

endpackage

// ==== verilog/opn_top.sv ====
`timescale 1ns/1ps
`include "opn_params.svh"

module opn_top (
    input  logic                   zero,     // Chip clock
    input  logic                   rst_n,
    input  logic                   cs_n,
    input  logic                   wr_n,
    input  logic                   a0,
    input  logic [`OPN_DATA_W-1:0] din,
    output logic [`OPN_DATA_W-1:0] dout,
    output logic                   irq_n,
    output logic [`OPN_LFO_W-1:0]  lfo_mod
);

    opn_timer_pkg::timer_cfg_t timer_cfg;
    opn_timer_pkg::lfo_cfg_t   lfo_cfg;
    opn_timer_pkg::ticks_t     ticks;
    logic                      clr_a, clr_b;
    logic                      flag_a, flag_b;

    // CPU port, status and interrupt
    opn_regs u_regs (
        .clk       (zero),
        .rst_n     (rst_n),
        .cs_n      (cs_n),
        .wr_n      (wr_n),
        .a0        (a0),
        .din       (din),
        .flag_a    (flag_a),
        .flag_b    (flag_b),
        .timer_cfg (timer_cfg),
        .clr_a     (clr_a),
        .clr_b     (clr_b),
        .lfo_cfg   (lfo_cfg),
        .dout      (dout),
        .irq_n     (irq_n)
    );

    opn_prescaler u_prescaler (
        .clk   (zero),
        .rst_n (rst_n),
        .ticks (ticks)
    );

    // Timer A, 10 bits
    opn_timer #(.WIDTH(`OPN_TA_W)) u_timer_a (
        .clk    (zero),
        .rst_n  (rst_n),
        .tick   (ticks.tick_a),
        .value  (timer_cfg.value_a),
        .load   (timer_cfg.load_a),
        .irq_en (timer_cfg.irq_en_a),
        .clr    (clr_a),
        .flag   (flag_a)
    );

    // Timer B, 8 bits, 16x slower tick
    opn_timer #(.WIDTH(`OPN_TB_W)) u_timer_b (
        .clk    (zero),
        .rst_n  (rst_n),
        .tick   (ticks.tick_b),
        .value  (timer_cfg.value_b),
        .load   (timer_cfg.load_b),
        .irq_en (timer_cfg.irq_en_b),
        .clr    (clr_b),
        .flag   (flag_b)
    );

    opn_lfo u_lfo (
        .clk     (zero),
        .rst_n   (rst_n),
        .cen_fm  (ticks.cen_fm),
        .cfg     (lfo_cfg),
        .lfo_mod (lfo_mod)
    );

endmodule
